//--- filelist.f
serdes_dbg_pkg.sv
prbs_source.sv
sample_fifo.sv
prbs_checker.sv
jtag_dbg.sv
serdes_dbg_top.sv
serdes_dbg_asserts.sv
tb_serdes_dbg.sv

//--- jtag_dbg.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_dbg (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  tck_i,
	input  wire logic                  tms_i,
	input  wire logic                  tdi_i,
	input  wire logic                  trst_n_i,
	input  wire serdes_dbg_pkg::cnt_t  total_bits_i,
	input  wire serdes_dbg_pkg::cnt_t  correct_bits_i,
	output logic                       tdo_o,
	output logic                       run_o,
	output logic                       freeze_o,
	output serdes_dbg_pkg::seed_t      seed_o,
	output logic                       inject_o
);
	logic [1:0]                        tck_sync;
	logic [1:0]                        tms_sync;
	logic [1:0]                        tdi_sync;
	logic [1:0]                        trst_sync;
	logic                              tck_q;
	logic                              tck_rise;
	logic                              tck_fall;
	logic                              tap_rst;
	serdes_dbg_pkg::tap_state_e        state;
	serdes_dbg_pkg::ir_t               ir_q;
	serdes_dbg_pkg::ir_t               ir_shift;
	logic [31:0]                       dr_shift;
	logic [31:0]                       dr_next;
	logic [4:0]                        dr_msb;
	logic [serdes_dbg_pkg::CTRL_W-1:0] ctrl_q;
	serdes_dbg_pkg::cnt_t              correct_snap;

	function automatic serdes_dbg_pkg::tap_state_e tap_next(
		input serdes_dbg_pkg::tap_state_e s,
		input logic                       tms
	);
		case (s)
			serdes_dbg_pkg::TAP_TEST_LOGIC_RESET:
				return tms ? serdes_dbg_pkg::TAP_TEST_LOGIC_RESET : serdes_dbg_pkg::TAP_RUN_TEST_IDLE;
			serdes_dbg_pkg::TAP_RUN_TEST_IDLE:
				return tms ? serdes_dbg_pkg::TAP_SELECT_DR : serdes_dbg_pkg::TAP_RUN_TEST_IDLE;
			serdes_dbg_pkg::TAP_SELECT_DR:
				return tms ? serdes_dbg_pkg::TAP_SELECT_IR : serdes_dbg_pkg::TAP_CAPTURE_DR;
			serdes_dbg_pkg::TAP_CAPTURE_DR, serdes_dbg_pkg::TAP_SHIFT_DR:
				return tms ? serdes_dbg_pkg::TAP_EXIT1_DR : serdes_dbg_pkg::TAP_SHIFT_DR;
			serdes_dbg_pkg::TAP_EXIT1_DR:
				return tms ? serdes_dbg_pkg::TAP_UPDATE_DR : serdes_dbg_pkg::TAP_PAUSE_DR;
			serdes_dbg_pkg::TAP_PAUSE_DR:
				return tms ? serdes_dbg_pkg::TAP_EXIT2_DR : serdes_dbg_pkg::TAP_PAUSE_DR;
			serdes_dbg_pkg::TAP_EXIT2_DR:
				return tms ? serdes_dbg_pkg::TAP_UPDATE_DR : serdes_dbg_pkg::TAP_SHIFT_DR;
			serdes_dbg_pkg::TAP_SELECT_IR:
				return tms ? serdes_dbg_pkg::TAP_TEST_LOGIC_RESET : serdes_dbg_pkg::TAP_CAPTURE_IR;
			serdes_dbg_pkg::TAP_CAPTURE_IR, serdes_dbg_pkg::TAP_SHIFT_IR:
				return tms ? serdes_dbg_pkg::TAP_EXIT1_IR : serdes_dbg_pkg::TAP_SHIFT_IR;
			serdes_dbg_pkg::TAP_EXIT1_IR:
				return tms ? serdes_dbg_pkg::TAP_UPDATE_IR : serdes_dbg_pkg::TAP_PAUSE_IR;
			serdes_dbg_pkg::TAP_PAUSE_IR:
				return tms ? serdes_dbg_pkg::TAP_EXIT2_IR : serdes_dbg_pkg::TAP_PAUSE_IR;
			serdes_dbg_pkg::TAP_EXIT2_IR:
				return tms ? serdes_dbg_pkg::TAP_UPDATE_IR : serdes_dbg_pkg::TAP_SHIFT_IR;
			default:
				return tms ? serdes_dbg_pkg::TAP_SELECT_DR : serdes_dbg_pkg::TAP_RUN_TEST_IDLE;
		endcase
	endfunction

	// Pins are sampled in the core clock domain
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tck_sync  <= '0;
			tms_sync  <= '0;
			tdi_sync  <= '0;
			trst_sync <= '0;
			tck_q     <= 1'b0;
		end else begin
			tck_sync  <= {tck_sync[0], tck_i};
			tms_sync  <= {tms_sync[0], tms_i};
			tdi_sync  <= {tdi_sync[0], tdi_i};
			trst_sync <= {trst_sync[0], trst_n_i};
			tck_q     <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] & ~tck_q;
	assign tck_fall = ~tck_sync[1] & tck_q;
	assign tap_rst  = !rst_n_i || !trst_sync[1];

	always_ff @(posedge clk_i) begin
		if (tap_rst) begin
			state    <= serdes_dbg_pkg::TAP_TEST_LOGIC_RESET;
			ir_q     <= serdes_dbg_pkg::IR_IDCODE;
			ir_shift <= '0;
		end else if (tck_rise) begin
			state <= tap_next(state, tms_sync[1]);
			case (state)
				serdes_dbg_pkg::TAP_TEST_LOGIC_RESET: ir_q <= serdes_dbg_pkg::IR_IDCODE;
				serdes_dbg_pkg::TAP_CAPTURE_IR:       ir_shift <= serdes_dbg_pkg::ir_t'(1);
				serdes_dbg_pkg::TAP_SHIFT_IR:         ir_shift <= {tdi_sync[1], ir_shift[3:1]};
				serdes_dbg_pkg::TAP_UPDATE_IR:        ir_q <= ir_shift;
				default: ;
			endcase
		end
	end

	// Chain length minus one, anything unknown is bypass
	always_comb begin
		dr_msb = 5'd0;
		case (ir_q)
			serdes_dbg_pkg::IR_IDCODE:  dr_msb = 5'd31;
			serdes_dbg_pkg::IR_TOTAL:   dr_msb = 5'd31;
			serdes_dbg_pkg::IR_CORRECT: dr_msb = 5'd31;
			serdes_dbg_pkg::IR_CTRL:    dr_msb = 5'(serdes_dbg_pkg::CTRL_W - 1);
			serdes_dbg_pkg::IR_BYPASS:  dr_msb = 5'd0;
			default: ;
		endcase
	end

	always_comb begin
		dr_next         = {1'b0, dr_shift[31:1]};
		dr_next[dr_msb] = tdi_sync[1];
	end

	// Reading TOTAL latches both counts, CORRECT then returns the latched one
	always_ff @(posedge clk_i) begin
		if (tck_rise && state == serdes_dbg_pkg::TAP_CAPTURE_DR) begin
			case (ir_q)
				serdes_dbg_pkg::IR_IDCODE:  dr_shift <= serdes_dbg_pkg::IDCODE_VALUE;
				serdes_dbg_pkg::IR_CTRL:    dr_shift <= 32'(ctrl_q);
				serdes_dbg_pkg::IR_TOTAL: begin
					dr_shift     <= total_bits_i;
					correct_snap <= correct_bits_i;
				end
				serdes_dbg_pkg::IR_CORRECT: dr_shift <= correct_snap;
				default:                    dr_shift <= '0;
			endcase
		end else if (tck_rise && state == serdes_dbg_pkg::TAP_SHIFT_DR) begin
			dr_shift <= dr_next;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ctrl_q   <= '0;
			inject_o <= 1'b0;
			tdo_o    <= 1'b0;
		end else begin
			inject_o <= 1'b0;
			if (tck_rise && state == serdes_dbg_pkg::TAP_UPDATE_DR &&
					ir_q == serdes_dbg_pkg::IR_CTRL) begin
				ctrl_q                              <= dr_shift[serdes_dbg_pkg::CTRL_W-1:0];
				ctrl_q[serdes_dbg_pkg::CTRL_INJECT] <= 1'b0;
				inject_o                            <= dr_shift[serdes_dbg_pkg::CTRL_INJECT];
			end
			if (tck_fall) begin
				case (state)
					serdes_dbg_pkg::TAP_SHIFT_IR: tdo_o <= ir_shift[0];
					serdes_dbg_pkg::TAP_SHIFT_DR: tdo_o <= dr_shift[0];
					default:                      tdo_o <= 1'b0;
				endcase
			end
		end
	end

	assign run_o    = ctrl_q[serdes_dbg_pkg::CTRL_RUN];
	assign freeze_o = ctrl_q[serdes_dbg_pkg::CTRL_FREEZE];
	assign seed_o   = ctrl_q[serdes_dbg_pkg::CTRL_SEED_MSB:serdes_dbg_pkg::CTRL_SEED_LSB];

endmodule

`default_nettype wire

//--- prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_checker (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  run_i,
	input  wire logic                  freeze_i,
	input  wire serdes_dbg_pkg::seed_t seed_i,
	input  wire logic                  chk_valid_i,
	input  wire serdes_dbg_pkg::word_t chk_data_i,
	output logic                       chk_credit_o,
	output serdes_dbg_pkg::cnt_t       total_bits_o,
	output serdes_dbg_pkg::cnt_t       correct_bits_o
);
	localparam int DEPTH = serdes_dbg_pkg::CHK_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	serdes_dbg_pkg::word_t in_mem [DEPTH];
	logic [PTR_W-1:0]      wr_sel;
	logic [PTR_W-1:0]      rd_sel;
	logic [CNT_W-1:0]      in_cnt;
	logic                  run_q;
	logic                  pop;
	serdes_dbg_pkg::seed_t lfsr;
	serdes_dbg_pkg::word_t rx_word;
	serdes_dbg_pkg::word_t ref_word;
	logic [3:0]            match_cnt;

	function automatic logic [3:0] count_matches(
		input serdes_dbg_pkg::word_t a,
		input serdes_dbg_pkg::word_t b
	);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < 8; i++) begin
			n = n + 4'(a[i] ~^ b[i]);
		end
		return n;
	endfunction

	// Freeze holds words in the buffer and withholds credits
	assign pop          = !freeze_i && (in_cnt != '0);
	assign chk_credit_o = pop;

	assign rx_word   = in_mem[rd_sel];
	assign ref_word  = serdes_dbg_pkg::prbs7_word(lfsr);
	assign match_cnt = count_matches(rx_word, ref_word);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			run_q          <= 1'b0;
			wr_sel         <= '0;
			rd_sel         <= '0;
			in_cnt         <= '0;
			total_bits_o   <= '0;
			correct_bits_o <= '0;
		end else begin
			run_q <= run_i;
			// Buffer depth is a power of two, pointers wrap on their own
			if (chk_valid_i) begin
				wr_sel <= wr_sel + 1'b1;
			end
			if (pop) begin
				rd_sel <= rd_sel + 1'b1;
			end
			in_cnt <= in_cnt + CNT_W'(chk_valid_i) - CNT_W'(pop);
			if (!run_q) begin
				total_bits_o   <= '0;
				correct_bits_o <= '0;
			end else if (pop) begin
				total_bits_o   <= total_bits_o + serdes_dbg_pkg::cnt_t'(8);
				correct_bits_o <= correct_bits_o + serdes_dbg_pkg::cnt_t'(match_cnt);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (chk_valid_i) begin
			in_mem[wr_sel] <= chk_data_i;
		end
	end

	// Same seeding rule as the source, so both start on the same word
	always_ff @(posedge clk_i) begin
		if (!run_q) begin
			lfsr <= serdes_dbg_pkg::prbs7_fix(seed_i);
		end else if (pop) begin
			lfsr <= serdes_dbg_pkg::prbs7_advance(lfsr);
		end
	end

endmodule

`default_nettype wire

//--- prbs_source.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_source #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  run_i,
	input  wire serdes_dbg_pkg::seed_t seed_i,
	input  wire logic                  inject_i,
	input  wire logic                  src_credit_i,
	output logic                       src_valid_o,
	output serdes_dbg_pkg::word_t      src_data_o
);
	localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

	logic                  run_q;
	logic                  inj_pend;
	logic [CRD_W-1:0]      credit_cnt;
	logic                  send;
	serdes_dbg_pkg::seed_t lfsr;

	// One word per cycle while running and the FIFO has room
	assign send = run_q && (credit_cnt != '0);

	assign src_valid_o = send;
	// Injected error lands on bit 0 of the word
	assign src_data_o = serdes_dbg_pkg::prbs7_word(lfsr) ^ serdes_dbg_pkg::word_t'(inj_pend);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			run_q      <= 1'b0;
			inj_pend   <= 1'b0;
			credit_cnt <= CRD_W'(FIFO_DEPTH);
		end else begin
			run_q <= run_i;
			if (send) begin
				inj_pend <= inject_i;
			end else if (inject_i) begin
				inj_pend <= 1'b1;
			end
			credit_cnt <= credit_cnt - CRD_W'(send) + CRD_W'(src_credit_i);
		end
	end

	// Seed is held in while stopped
	always_ff @(posedge clk_i) begin
		if (!run_q) begin
			lfsr <= serdes_dbg_pkg::prbs7_fix(seed_i);
		end else if (send) begin
			lfsr <= serdes_dbg_pkg::prbs7_advance(lfsr);
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the log

rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_serdes_dbg \
	-f filelist.f -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }

//--- sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  src_valid_i,
	input  wire serdes_dbg_pkg::word_t src_data_i,
	input  wire logic                  chk_credit_i,
	output logic                       src_credit_o,
	output logic                       chk_valid_o,
	output serdes_dbg_pkg::word_t      chk_data_o
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(serdes_dbg_pkg::CHK_BUF_DEPTH + 1);

	serdes_dbg_pkg::word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      fill_cnt;
	logic [CRD_W-1:0]      chk_crd;
	logic                  pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Oldest entry goes out as soon as the checker has space
	assign pop = (fill_cnt != '0) && (chk_crd != '0);

	assign chk_valid_o  = pop;
	assign chk_data_o   = mem[rd_ptr];
	assign src_credit_o = pop;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill_cnt <= '0;
			chk_crd  <= CRD_W'(serdes_dbg_pkg::CHK_BUF_DEPTH);
		end else begin
			if (src_valid_i) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			fill_cnt <= fill_cnt + CNT_W'(src_valid_i) - CNT_W'(pop);
			chk_crd  <= chk_crd - CRD_W'(pop) + CRD_W'(chk_credit_i);
		end
	end

	// Source credits guarantee a free slot on every push
	always_ff @(posedge clk_i) begin
		if (src_valid_i) begin
			mem[wr_ptr] <= src_data_i;
		end
	end

endmodule

`default_nettype wire

//--- serdes_dbg_asserts.sv
`timescale 1ns/1ps

module serdes_dbg_asserts #(
	parameter int FIFO_DEPTH = 4
) (
	input logic                                  clk_i,
	input logic                                  rst_n_i,
	input logic                                  src_valid_i,
	input logic                                  src_credit_i,
	input logic [$clog2(FIFO_DEPTH + 1)-1:0]     fifo_fill_i,
	input logic                                  freeze_i,
	input logic                                  inject_pulse_i,
	input serdes_dbg_pkg::cnt_t                  total_bits_i,
	input serdes_dbg_pkg::cnt_t                  correct_bits_i
);
	int error_count = 0;
	int src_credits;

	// Credits as seen on the source-to-FIFO link
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			src_credits <= FIFO_DEPTH;
		end else begin
			src_credits <= src_credits - int'(src_valid_i) + int'(src_credit_i);
		end
	end

	valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		src_valid_i |-> (src_credits != 0))
	else begin
		$error("src_valid asserted with zero source credits");
		error_count++;
	end

	fifo_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		int'(fifo_fill_i) <= FIFO_DEPTH)
	else begin
		$error("FIFO occupancy above FIFO_DEPTH");
		error_count++;
	end

	// No pop during a frozen cycle, so the next sample is unchanged
	counters_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$past(freeze_i) |-> ($stable(total_bits_i) && $stable(correct_bits_i)))
	else begin
		$error("bit counters changed while freeze was high");
		error_count++;
	end

	inject_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		inject_pulse_i |=> !inject_pulse_i)
	else begin
		$error("inject_pulse longer than one cycle");
		error_count++;
	end

endmodule

bind serdes_dbg_top serdes_dbg_asserts #(
	.FIFO_DEPTH (FIFO_DEPTH)
) i_asserts (
	.clk_i          (clk_i),
	.rst_n_i        (rst_n_i),
	.src_valid_i    (src_valid),
	.src_credit_i   (src_credit),
	.fifo_fill_i    (i_fifo.fill_cnt),
	.freeze_i       (freeze),
	.inject_pulse_i (inject_pulse),
	.total_bits_i   (total_bits),
	.correct_bits_i (correct_bits)
);

//--- serdes_dbg_pkg.sv
package serdes_dbg_pkg;

	typedef logic [7:0]  word_t;
	typedef logic [6:0]  seed_t;
	typedef logic [31:0] cnt_t;
	typedef logic [3:0]  ir_t;

	localparam ir_t IR_IDCODE  = 4'b0001;
	localparam ir_t IR_CTRL    = 4'b0010;
	localparam ir_t IR_TOTAL   = 4'b0011;
	localparam ir_t IR_CORRECT = 4'b0100;
	localparam ir_t IR_BYPASS  = 4'b1111;

	localparam logic [31:0] IDCODE_VALUE = 32'h0B41_7C0F;

	// Control register layout
	localparam int CTRL_W        = 16;
	localparam int CTRL_RUN      = 0;
	localparam int CTRL_FREEZE   = 1;
	localparam int CTRL_INJECT   = 2;
	localparam int CTRL_SEED_LSB = 8;
	localparam int CTRL_SEED_MSB = 14;

	// Checker input buffer depth, also the FIFO's initial downstream credit
	localparam int CHK_BUF_DEPTH = 2;

	// Standard 1149.1 encodings
	typedef enum logic [3:0] {
		TAP_TEST_LOGIC_RESET = 4'hF,
		TAP_RUN_TEST_IDLE    = 4'hC,
		TAP_SELECT_DR        = 4'h7,
		TAP_CAPTURE_DR       = 4'h6,
		TAP_SHIFT_DR         = 4'h2,
		TAP_EXIT1_DR         = 4'h1,
		TAP_PAUSE_DR         = 4'h3,
		TAP_EXIT2_DR         = 4'h0,
		TAP_UPDATE_DR        = 4'h5,
		TAP_SELECT_IR        = 4'h4,
		TAP_CAPTURE_IR       = 4'hE,
		TAP_SHIFT_IR         = 4'hA,
		TAP_EXIT1_IR         = 4'h9,
		TAP_PAUSE_IR         = 4'hB,
		TAP_EXIT2_IR         = 4'h8,
		TAP_UPDATE_IR        = 4'hD
	} tap_state_e;

	// An all-zero seed would lock the LFSR
	function automatic seed_t prbs7_fix(input seed_t s);
		return (s == '0) ? '1 : s;
	endfunction

	// x^7 + x^6 + 1, eight steps per word
	function automatic seed_t prbs7_advance(input seed_t s);
		seed_t st;
		st = s;
		for (int i = 0; i < 8; i++) begin
			st = {st[5:0], st[6] ^ st[5]};
		end
		return st;
	endfunction

	// Bit i of the word is the feedback bit of step i
	function automatic word_t prbs7_word(input seed_t s);
		seed_t st;
		word_t w;
		st = s;
		for (int i = 0; i < 8; i++) begin
			w[i] = st[6] ^ st[5];
			st = {st[5:0], w[i]};
		end
		return w;
	endfunction

endpackage

//--- serdes_dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_dbg_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic      tdo_o
);
	// Bridge controls
	logic                  run;
	logic                  freeze;
	logic                  inject_pulse;
	serdes_dbg_pkg::seed_t seed;

	// Source to FIFO
	logic                  src_valid;
	logic                  src_credit;
	serdes_dbg_pkg::word_t src_data;

	// FIFO to checker
	logic                  chk_valid;
	logic                  chk_credit;
	serdes_dbg_pkg::word_t chk_data;

	serdes_dbg_pkg::cnt_t  total_bits;
	serdes_dbg_pkg::cnt_t  correct_bits;

	jtag_dbg i_jtag (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.tck_i          (tck_i),
		.tms_i          (tms_i),
		.tdi_i          (tdi_i),
		.trst_n_i       (trst_n_i),
		.total_bits_i   (total_bits),
		.correct_bits_i (correct_bits),
		.tdo_o          (tdo_o),
		.run_o          (run),
		.freeze_o       (freeze),
		.seed_o         (seed),
		.inject_o       (inject_pulse)
	);

	prbs_source #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_source (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.run_i        (run),
		.seed_i       (seed),
		.inject_i     (inject_pulse),
		.src_credit_i (src_credit),
		.src_valid_o  (src_valid),
		.src_data_o   (src_data)
	);

	sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.src_valid_i  (src_valid),
		.src_data_i   (src_data),
		.chk_credit_i (chk_credit),
		.src_credit_o (src_credit),
		.chk_valid_o  (chk_valid),
		.chk_data_o   (chk_data)
	);

	prbs_checker i_checker (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.run_i          (run),
		.freeze_i       (freeze),
		.seed_i         (seed),
		.chk_valid_i    (chk_valid),
		.chk_data_i     (chk_data),
		.chk_credit_o   (chk_credit),
		.total_bits_o   (total_bits),
		.correct_bits_o (correct_bits)
	);

endmodule

`default_nettype wire

//--- tb_serdes_dbg.sv
`timescale 1ns/1ps

module tb_serdes_dbg;

	// About 10000 cycles of scenarios, kept well below this limit
	localparam int MAX_CYCLES = 60000;

	logic        clk;
	logic        rst_n;
	logic        tck;
	logic        tms;
	logic        tdi;
	logic        trst_n;
	logic        tdo;
	logic [31:0] lcg_state;
	int          cycle_cnt = 0;

	serdes_dbg_top #(
		.FIFO_DEPTH (4)
	) i_dut (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.tck_i    (tck),
		.tms_i    (tms),
		.tdi_i    (tdi),
		.trst_n_i (trst_n),
		.tdo_o    (tdo)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic wait_clk(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
				$time, name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("** Error at %0t ns: %s", $time, what);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// One TCK period of 8 clk, tdo sampled just before the rise
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(negedge clk);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (4) @(negedge clk);
		tdo_v = tdo;
		tck = 1'b1;
		repeat (3) @(negedge clk);
	endtask

	task automatic tap_reset();
		logic dummy;
		repeat (5) tck_cycle(1'b1, 1'b0, dummy);
		tck_cycle(1'b0, 1'b0, dummy);
	endtask

	task automatic shift_ir(input serdes_dbg_pkg::ir_t code);
		logic dummy;
		tck_cycle(1'b1, 1'b0, dummy);
		tck_cycle(1'b1, 1'b0, dummy);
		// Capture-IR, then Shift-IR
		tck_cycle(1'b0, 1'b0, dummy);
		tck_cycle(1'b0, 1'b0, dummy);
		for (int i = 0; i < 4; i++) begin
			tck_cycle(i == 3, code[i], dummy);
		end
		tck_cycle(1'b1, 1'b0, dummy);
		tck_cycle(1'b0, 1'b0, dummy);
	endtask

	task automatic shift_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		// Update-DR, back to idle
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic write_ctrl(input serdes_dbg_pkg::seed_t seed, input logic run_v,
			input logic freeze_v, input logic inject_v);
		logic [31:0] ctrl;
		logic [31:0] dummy;
		ctrl = '0;
		ctrl[serdes_dbg_pkg::CTRL_RUN] = run_v;
		ctrl[serdes_dbg_pkg::CTRL_FREEZE] = freeze_v;
		ctrl[serdes_dbg_pkg::CTRL_INJECT] = inject_v;
		ctrl[serdes_dbg_pkg::CTRL_SEED_MSB:serdes_dbg_pkg::CTRL_SEED_LSB] = seed;
		shift_ir(serdes_dbg_pkg::IR_CTRL);
		shift_dr(serdes_dbg_pkg::CTRL_W, ctrl, dummy);
	endtask

	// TOTAL first, its capture also latches CORRECT
	task automatic read_counts(output logic [31:0] total, output logic [31:0] correct);
		shift_ir(serdes_dbg_pkg::IR_TOTAL);
		shift_dr(32, '0, total);
		shift_ir(serdes_dbg_pkg::IR_CORRECT);
		shift_dr(32, '0, correct);
	endtask

	always @(negedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (i_dut.i_asserts.error_count != 0) begin
			$display("A concurrent assertion on the data path failed");
			$display("Some tests failed");
			$fatal(1);
		end else if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d clock cycles, the scenarios did not finish", cycle_cnt);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	initial begin
		logic [31:0]           rd_val;
		logic [31:0]           total_a;
		logic [31:0]           correct_a;
		logic [31:0]           total_b;
		logic [31:0]           correct_b;
		logic [15:0]           pattern;
		serdes_dbg_pkg::seed_t seed;
		int                    n_inject;

		rst_n = 1'b0;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		lcg_state = 32'd53;
		wait_clk(10);
		rst_n = 1'b1;
		wait_clk(4);
		tap_reset();

		// IDCODE is selected out of reset
		shift_dr(32, '0, rd_val);
		check_equal("IDCODE", serdes_dbg_pkg::IDCODE_VALUE, rd_val);

		seed = 7'(next_random() >> 16);
		write_ctrl(seed, 1'b1, 1'b0, 1'b0);
		wait_clk(400);
		read_counts(total_a, correct_a);
		check_true(total_a != 0, "TOTAL stayed zero while the pattern was running");
		check_true(total_a[2:0] == 3'b0, "TOTAL is not a whole number of words");
		check_equal("CORRECT", total_a, correct_a);

		// Back-pressure from a frozen checker
		write_ctrl(seed, 1'b1, 1'b1, 1'b0);
		read_counts(total_a, correct_a);
		wait_clk(300);
		read_counts(total_b, correct_b);
		check_equal("TOTAL under freeze", total_a, total_b);
		write_ctrl(seed, 1'b1, 1'b0, 1'b0);
		wait_clk(300);
		read_counts(total_b, correct_b);
		check_true(total_b > total_a, "TOTAL did not grow after freeze was released");
		check_equal("CORRECT after freeze", total_b, correct_b);

		n_inject = 1 + int'((next_random() >> 16) % 32'd5);
		repeat (n_inject) begin
			write_ctrl(seed, 1'b1, 1'b0, 1'b1);
			wait_clk(50);
		end
		read_counts(total_a, correct_a);
		check_equal("TOTAL - CORRECT", 32'(n_inject), total_a - correct_a);

		// Bypass returns the pattern one TCK late, behind the captured zero
		pattern = 16'(next_random() >> 8);
		shift_ir(serdes_dbg_pkg::IR_BYPASS);
		shift_dr(17, 32'(pattern), rd_val);
		check_equal("bypass TDO", 32'(pattern) << 1, rd_val);

		write_ctrl(seed, 1'b0, 1'b0, 1'b0);
		read_counts(total_a, correct_a);
		check_equal("TOTAL while stopped", 32'd0, total_a);
		seed = 7'(next_random() >> 16);
		write_ctrl(seed, 1'b1, 1'b0, 1'b0);
		wait_clk(400);
		read_counts(total_a, correct_a);
		check_true(total_a != 0, "TOTAL stayed zero after the restart with a new seed");
		check_equal("CORRECT after reseed", total_a, correct_a);

		if (i_dut.i_asserts.error_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule
